// File: gpioPkg.sv
// GPIO shared definitions.
// Register map, configuration bit positions and alternate-function pin numbers.

package gpioPkg;

	// ------------------------------
	// Register addresses.
	// ------------------------------
	typedef enum logic [1:0] {
		ADDR_CFG = 2'd0, // Config and interrupt status.
		ADDR_IN  = 2'd1, // Synchronized pins, read only.
		ADDR_DIR = 2'd2, // Direction, 1 drives the pin.
		ADDR_OUT = 2'd3  // Output value.
	} regAddrE;

	// ------------------------------
	// Config bits in the data word.
	// ------------------------------
	localparam int CFG_UART = 14; // UART on pins 14/15.
	localparam int CFG_I2C  = 12; // I2C on pins 12/13.
	localparam int CFG_TMR2 = 11;
	localparam int CFG_TMR3 = 10;
	localparam int CFG_INTH = 9;  // High interrupt enable.
	localparam int CFG_INTL = 8;  // Low interrupt enable.

	// Pending flags in config readback.
	localparam int STS_INTH = 1;
	localparam int STS_INTL = 0;

	// ------------------------------
	// Alternate-function pins.
	// ------------------------------
	localparam int PIN_UART_TX = 14;
	localparam int PIN_UART_RX = 15;
	localparam int PIN_SDA     = 12;
	localparam int PIN_SCL     = 13;
	localparam int PIN_TMR2    = 11;
	localparam int PIN_TMR3    = 10;
	localparam int PIN_INTH    = 9;
	localparam int PIN_INTL    = 8;

endpackage

// File: pinSync.sv
// Pin input synchronizer.
// Multi-stage flop chain per pin into the i_clk domain.
`timescale 1ns/1ps

module pinSync #(
	parameter int PIN_COUNT   = 16,
	parameter int SYNC_STAGES = 2
) (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic [PIN_COUNT-1:0] i_async, // Raw pin levels.
	output logic [PIN_COUNT-1:0] o_sync
);

	logic [PIN_COUNT-1:0] stages [SYNC_STAGES]; // Stage 0 is metastable.

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < SYNC_STAGES; i++) stages[i] <= '0;
		end else begin
			stages[0] <= i_async;
			for (int i = 1; i < SYNC_STAGES; i++) stages[i] <= stages[i-1]; // Shift.
		end
	end

	assign o_sync = stages[SYNC_STAGES-1]; // Last stage is stable.

	// Output trails input by exactly SYNC_STAGES edges once out of reset.
	assert property (@(posedge i_clk) disable iff (i_rst)
		(!i_rst)[*SYNC_STAGES] |=> (o_sync == $past(i_async, SYNC_STAGES)))
		else $error("pinSync: output does not match delayed input");

endmodule

// File: gpioRegs.sv
// GPIO register file.
// Config, direction and output registers with memory-map decode and read mux.
`timescale 1ns/1ps

module gpioRegs (
	input  logic        i_clk,
	input  logic        i_rst,

	// Memory map bus.
	input  logic [1:0]  i_memAddr,
	input  logic [15:0] i_memDataIn,
	input  logic        i_memWrEn,
	output logic [15:0] o_memDataOut,

	// Status inputs.
	input  logic [15:0] i_syncPins,
	input  logic        i_intPendH,
	input  logic        i_intPendL,

	// Register outputs.
	output logic [5:0]  o_cfg,      // {uart, i2c, tmr2, tmr3, intH, intL}.
	output logic [15:0] o_dirReg,
	output logic [15:0] o_outReg,
	output logic        o_clrIntH,  // Write-one-to-clear pulses.
	output logic        o_clrIntL
);

	gpioPkg::regAddrE regAddr;
	logic             cfgWrite;
	logic [5:0]       cfgQ;
	logic [5:0]       cfgNext;      // Config bits picked from the data word.
	logic [15:0]      dirQ, outQ;
	logic [15:0]      cfgRead;

	// ------------------------------
	// Address decode.
	// ------------------------------
	assign regAddr  = gpioPkg::regAddrE'(i_memAddr);
	assign cfgWrite = i_memWrEn && (regAddr == gpioPkg::ADDR_CFG);

	// Clear pulses ride along with a config write.
	assign o_clrIntH = cfgWrite & i_memDataIn[gpioPkg::STS_INTH];
	assign o_clrIntL = cfgWrite & i_memDataIn[gpioPkg::STS_INTL];

	assign cfgNext = {i_memDataIn[gpioPkg::CFG_UART],
	                  i_memDataIn[gpioPkg::CFG_I2C],
	                  i_memDataIn[gpioPkg::CFG_TMR2],
	                  i_memDataIn[gpioPkg::CFG_TMR3],
	                  i_memDataIn[gpioPkg::CFG_INTH],
	                  i_memDataIn[gpioPkg::CFG_INTL]};

	// ------------------------------
	// Registers.
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			cfgQ <= '0;
			dirQ <= '0; // All pins input.
			outQ <= '0;
		end else if (i_memWrEn) begin
			unique case (regAddr)
				gpioPkg::ADDR_CFG: cfgQ <= cfgNext;
				gpioPkg::ADDR_DIR: dirQ <= i_memDataIn;
				gpioPkg::ADDR_OUT: outQ <= i_memDataIn;
				default: ; // Input register is read only.
			endcase
		end
	end

	assign o_cfg    = cfgQ;
	assign o_dirReg = dirQ;
	assign o_outReg = outQ;

	// ------------------------------
	// Read mux.
	// ------------------------------
	always_comb begin
		cfgRead                    = '0; // Reserved bits read zero.
		cfgRead[gpioPkg::CFG_UART] = cfgQ[5];
		cfgRead[gpioPkg::CFG_I2C]  = cfgQ[4];
		cfgRead[gpioPkg::CFG_TMR2] = cfgQ[3];
		cfgRead[gpioPkg::CFG_TMR3] = cfgQ[2];
		cfgRead[gpioPkg::CFG_INTH] = cfgQ[1];
		cfgRead[gpioPkg::CFG_INTL] = cfgQ[0];
		cfgRead[gpioPkg::STS_INTH] = i_intPendH; // Pending flags.
		cfgRead[gpioPkg::STS_INTL] = i_intPendL;
	end

	always_comb begin
		unique case (regAddr)
			gpioPkg::ADDR_CFG: o_memDataOut = cfgRead;
			gpioPkg::ADDR_IN:  o_memDataOut = i_syncPins;
			gpioPkg::ADDR_DIR: o_memDataOut = dirQ;
			default:           o_memDataOut = outQ;
		endcase
	end

	// A clear pulse only comes with an edge that loads the config register.
	assert property (@(posedge i_clk) disable iff (i_rst)
		(o_clrIntH || o_clrIntL) |=> (cfgQ == $past(cfgNext)))
		else $error("gpioRegs: clear pulse outside config write");

endmodule

// File: intDetect.sv
// Interrupt detect for pins 9 and 8.
// Rising-edge capture into sticky pending flags with write-one-to-clear.
`timescale 1ns/1ps

module intDetect (
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic [15:0] i_syncPins,
	input  logic        i_enH,
	input  logic        i_enL,
	input  logic        i_clrH,
	input  logic        i_clrL,
	output logic        o_pendH,
	output logic        o_pendL,
	output logic        o_intH, // Pending AND enable.
	output logic        o_intL
);

	// Bit 1 is the high pin, bit 0 the low pin.
	logic [1:0] pinLvl, prevLvl, rise;
	logic [1:0] en, clr, pend;

	assign pinLvl = {i_syncPins[gpioPkg::PIN_INTH], i_syncPins[gpioPkg::PIN_INTL]};
	assign en     = {i_enH, i_enL};
	assign clr    = {i_clrH, i_clrL};
	assign rise   = pinLvl & ~prevLvl; // Low to high since last edge.

	// ------------------------------
	// Edge history and flags.
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			prevLvl <= '0;
			pend    <= '0;
		end else begin
			prevLvl <= pinLvl;
			pend    <= (rise & en) | (pend & ~clr); // Set wins over clear.
		end
	end

	assign o_pendH = pend[1];
	assign o_pendL = pend[0];
	assign o_intH  = pend[1] & i_enH;
	assign o_intL  = pend[0] & i_enL;

	// A flag may only rise when its enable was high on the setting edge.
	assert property (@(posedge i_clk) disable iff (i_rst)
		((pend & ~$past(pend) & ~$past(en)) == 2'b00))
		else $error("intDetect: pending flag set while disabled");

endmodule

// File: pinMux.sv
// Pin output mux.
// Alternate functions override the per-pin output value and output enable.
`timescale 1ns/1ps

module pinMux (
	input  logic [5:0]  i_cfg,     // {uart, i2c, tmr2, tmr3, intH, intL}.
	input  logic [15:0] i_dirReg,
	input  logic [15:0] i_outReg,

	// Peripheral drive.
	input  logic        i_uartTx,
	input  logic        i_sdaOut,  // Zero pulls low.
	input  logic        i_sclOut,
	input  logic        i_tmr2Out,
	input  logic        i_tmr3Out,

	output logic [15:0] o_pinOut,
	output logic [15:0] o_pinOe    // One drives the pin.
);

	logic cfgUart, cfgI2c, cfgTmr2, cfgTmr3, cfgIntH, cfgIntL;

	assign cfgUart = i_cfg[5];
	assign cfgI2c  = i_cfg[4];
	assign cfgTmr2 = i_cfg[3];
	assign cfgTmr3 = i_cfg[2];
	assign cfgIntH = i_cfg[1];
	assign cfgIntL = i_cfg[0];

	// ------------------------------
	// Default plus overrides.
	// ------------------------------
	always_comb begin
		o_pinOut = i_outReg; // Plain GPIO.
		o_pinOe  = i_dirReg;

		if (cfgUart) begin
			o_pinOut[gpioPkg::PIN_UART_TX] = i_uartTx;
			o_pinOe[gpioPkg::PIN_UART_TX]  = 1'b1;
			o_pinOe[gpioPkg::PIN_UART_RX]  = 1'b0; // RX listens only.
		end

		// Open drain, enable only to pull low.
		if (cfgI2c) begin
			o_pinOut[gpioPkg::PIN_SDA] = 1'b0;
			o_pinOe[gpioPkg::PIN_SDA]  = ~i_sdaOut;
			o_pinOut[gpioPkg::PIN_SCL] = 1'b0;
			o_pinOe[gpioPkg::PIN_SCL]  = ~i_sclOut;
		end

		if (cfgTmr2) begin
			o_pinOut[gpioPkg::PIN_TMR2] = i_tmr2Out;
			o_pinOe[gpioPkg::PIN_TMR2]  = 1'b1;
		end

		if (cfgTmr3) begin
			o_pinOut[gpioPkg::PIN_TMR3] = i_tmr3Out;
			o_pinOe[gpioPkg::PIN_TMR3]  = 1'b1;
		end

		if (cfgIntH) o_pinOe[gpioPkg::PIN_INTH] = 1'b0; // Interrupt pins sense only.
		if (cfgIntL) o_pinOe[gpioPkg::PIN_INTL] = 1'b0;
	end

	// I2C lines never drive high.
	always_comb begin
		if (cfgI2c) begin
			assert final ((o_pinOut[gpioPkg::PIN_SDA] == 1'b0) &&
			              (o_pinOut[gpioPkg::PIN_SCL] == 1'b0))
				else $error("pinMux: I2C pin driven high");
		end
	end

endmodule

// File: gpioSubsystem.sv
// GPIO subsystem top.
// Joins the synchronizer, register file, interrupt detect and pin mux.
`timescale 1ns/1ps

module gpioSubsystem #(
	parameter int PIN_COUNT   = 16,
	parameter int SYNC_STAGES = 2
) (
	input  logic                 i_clk,
	input  logic                 i_rst,

	// Memory map bus.
	input  logic [1:0]           i_memAddr,
	input  logic [15:0]          i_memDataIn,
	input  logic                 i_memWrEn,
	output logic [15:0]          o_memDataOut,

	// Pins, tristate buffer lives on the board.
	input  logic [PIN_COUNT-1:0] i_pinIn,
	output logic [PIN_COUNT-1:0] o_pinOut,
	output logic [PIN_COUNT-1:0] o_pinOe,

	// Peripheral side.
	input  logic                 i_uartTx,
	input  logic                 i_sdaOut,
	input  logic                 i_sclOut,
	input  logic                 i_tmr2Out,
	input  logic                 i_tmr3Out,
	output logic                 o_uartRx,
	output logic                 o_sdaIn,
	output logic                 o_sclIn,
	output logic                 o_intH,
	output logic                 o_intL
);

	// ------------------------------
	// Internal wires.
	// ------------------------------
	logic [PIN_COUNT-1:0] syncPins;
	logic [5:0]           cfg;
	logic [15:0]          dirReg, outReg;
	logic                 clrIntH, clrIntL;
	logic                 pendH, pendL;

	pinSync #(
		.PIN_COUNT  (PIN_COUNT),
		.SYNC_STAGES(SYNC_STAGES)
	) u_pinSync (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_async(i_pinIn),
		.o_sync (syncPins)
	);

	gpioRegs u_gpioRegs (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_memAddr   (i_memAddr),
		.i_memDataIn (i_memDataIn),
		.i_memWrEn   (i_memWrEn),
		.o_memDataOut(o_memDataOut),
		.i_syncPins  (syncPins),
		.i_intPendH  (pendH),
		.i_intPendL  (pendL),
		.o_cfg       (cfg),
		.o_dirReg    (dirReg),
		.o_outReg    (outReg),
		.o_clrIntH   (clrIntH),
		.o_clrIntL   (clrIntL)
	);

	intDetect u_intDetect (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_syncPins(syncPins),
		.i_enH     (cfg[1]), // Interrupt enables from config.
		.i_enL     (cfg[0]),
		.i_clrH    (clrIntH),
		.i_clrL    (clrIntL),
		.o_pendH   (pendH),
		.o_pendL   (pendL),
		.o_intH    (o_intH),
		.o_intL    (o_intL)
	);

	pinMux u_pinMux (
		.i_cfg    (cfg),
		.i_dirReg (dirReg),
		.i_outReg (outReg),
		.i_uartTx (i_uartTx),
		.i_sdaOut (i_sdaOut),
		.i_sclOut (i_sclOut),
		.i_tmr2Out(i_tmr2Out),
		.i_tmr3Out(i_tmr3Out),
		.o_pinOut (o_pinOut),
		.o_pinOe  (o_pinOe)
	);

	// Peripheral inputs straight from synced pins.
	assign o_uartRx = syncPins[gpioPkg::PIN_UART_RX];
	assign o_sdaIn  = syncPins[gpioPkg::PIN_SDA];
	assign o_sclIn  = syncPins[gpioPkg::PIN_SCL];

endmodule

// File: tb_gpioSubsystem.sv
// GPIO subsystem testbench.
// Random bus, pin and interrupt traffic checked against a cycle model.
`timescale 1ns/1ps

module tb_gpioSubsystem;

	localparam int SYNC_STAGES  = 2;
	localparam int RESET_CYCLES = 8;
	localparam int N_REGS       = 400; // Cycles per random test.
	localparam int N_SYNC       = 300;
	localparam int N_ALT        = 500;
	localparam int N_INT        = 800;
	localparam int TOTAL_CYCLES = RESET_CYCLES + 4 + N_REGS + N_SYNC + N_ALT + N_INT;

	logic        clk, rst;
	logic [1:0]  memAddr;
	logic [15:0] memDataIn, memDataOut;
	logic        memWrEn;
	logic [15:0] pinIn, pinOut, pinOe;
	logic        uartTx, sdaOut, sclOut, tmr2Out, tmr3Out;
	logic        uartRx, sdaIn, sclIn, intH, intL;

	// Model state, updated once per rising edge.
	logic [5:0]  mCfg; // {uart, i2c, tmr2, tmr3, intH, intL}.
	logic [15:0] mDir, mOut;
	logic [1:0]  mPend, mPrev; // Bit 1 is pin 9, bit 0 pin 8.
	logic [15:0] mStage [SYNC_STAGES];
	logic [15:0] expOut, expOe, expRead;
	int          errors, checks, testsRun, testsFailed;

	gpioSubsystem #(.PIN_COUNT(16), .SYNC_STAGES(SYNC_STAGES)) dut (
		.i_clk(clk), .i_rst(rst),
		.i_memAddr(memAddr), .i_memDataIn(memDataIn), .i_memWrEn(memWrEn),
		.o_memDataOut(memDataOut),
		.i_pinIn(pinIn), .o_pinOut(pinOut), .o_pinOe(pinOe),
		.i_uartTx(uartTx), .i_sdaOut(sdaOut), .i_sclOut(sclOut),
		.i_tmr2Out(tmr2Out), .i_tmr3Out(tmr3Out),
		.o_uartRx(uartRx), .o_sdaIn(sdaIn), .o_sclIn(sclIn),
		.o_intH(intH), .o_intL(intL)
	);

	always #10 clk = ~clk; // 20 ns period.

	// Watchdog sized from the test lengths.
	initial begin
		#(TOTAL_CYCLES * 20 + 1000);
		$display("Watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ------------------------------
	// Reference model.
	// ------------------------------
	task automatic modelEdge();
		logic [15:0] sync;
		logic [1:0]  rise, clr;
		sync = mStage[SYNC_STAGES-1]; // Synced pins before this edge.
		rise = {sync[gpioPkg::PIN_INTH], sync[gpioPkg::PIN_INTL]} & ~mPrev;
		clr  = (memWrEn && memAddr == 2'd0) ? memDataIn[1:0] : 2'b00;
		if (rst) begin
			mCfg  = '0;
			mDir  = '0;
			mOut  = '0;
			mPend = '0;
			mPrev = '0;
			for (int i = 0; i < SYNC_STAGES; i++) mStage[i] = '0;
		end else begin
			mPend = (rise & mCfg[1:0]) | (mPend & ~clr); // Set beats clear.
			mPrev = {sync[gpioPkg::PIN_INTH], sync[gpioPkg::PIN_INTL]};
			for (int i = SYNC_STAGES - 1; i > 0; i--) mStage[i] = mStage[i-1];
			mStage[0] = pinIn;
			if (memWrEn) begin
				case (memAddr)
					2'd0: mCfg = {memDataIn[gpioPkg::CFG_UART], memDataIn[gpioPkg::CFG_I2C],
					              memDataIn[gpioPkg::CFG_TMR2], memDataIn[gpioPkg::CFG_TMR3],
					              memDataIn[gpioPkg::CFG_INTH], memDataIn[gpioPkg::CFG_INTL]};
					2'd2: mDir = memDataIn;
					2'd3: mOut = memDataIn;
					default: ; // Input register ignores writes.
				endcase
			end
		end
	endtask

	// Expected pins and read data for the current inputs.
	task automatic computeExpected();
		expOut = mOut;
		expOe  = mDir;
		if (mCfg[5]) begin
			expOut[14] = uartTx;
			expOe[14]  = 1'b1;
			expOe[15]  = 1'b0; // RX pin listens.
		end
		if (mCfg[4]) begin
			expOut[12] = 1'b0;
			expOut[13] = 1'b0;
			expOe[12]  = ~sdaOut;
			expOe[13]  = ~sclOut;
		end
		if (mCfg[3]) {expOut[11], expOe[11]} = {tmr2Out, 1'b1};
		if (mCfg[2]) {expOut[10], expOe[10]} = {tmr3Out, 1'b1};
		if (mCfg[1]) expOe[9] = 1'b0;
		if (mCfg[0]) expOe[8] = 1'b0;
		case (memAddr)
			2'd0:    expRead = {1'b0, mCfg[5], 1'b0, mCfg[4:0], 6'd0, mPend};
			2'd1:    expRead = mStage[SYNC_STAGES-1];
			2'd2:    expRead = mDir;
			default: expRead = mOut;
		endcase
	endtask

	// ------------------------------
	// Checks and stimulus.
	// ------------------------------
	task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Fail %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic checkOutputs();
		logic [15:0] sync;
		sync = mStage[SYNC_STAGES-1];
		computeExpected();
		checkVal("o_memDataOut", memDataOut, expRead);
		checkVal("o_pinOut", pinOut, expOut);
		checkVal("o_pinOe", pinOe, expOe);
		checkVal("o_uartRx", {15'd0, uartRx}, {15'd0, sync[15]});
		checkVal("o_sdaIn", {15'd0, sdaIn}, {15'd0, sync[12]});
		checkVal("o_sclIn", {15'd0, sclIn}, {15'd0, sync[13]});
		checkVal("o_intH", {15'd0, intH}, {15'd0, mPend[1] & mCfg[1]});
		checkVal("o_intL", {15'd0, intL}, {15'd0, mPend[0] & mCfg[0]});
	endtask

	// One clock: model the edge, drive new inputs, check at the falling edge.
	task automatic runCycle(input logic r, input logic [1:0] addr, input logic [15:0] data,
	                        input logic we, input logic [15:0] pins, input logic [4:0] periph);
		@(posedge clk);
		modelEdge();
		rst       <= r;
		memAddr   <= addr;
		memDataIn <= data;
		memWrEn   <= we;
		pinIn     <= pins;
		{uartTx, sdaOut, sclOut, tmr2Out, tmr3Out} <= periph;
		@(negedge clk);
		checkOutputs();
	endtask

	task automatic endTest(input string name, input int errBefore);
		testsRun++;
		if (errors == errBefore) $display("Test %s: passed", name);
		else begin
			$display("Test %s: failed with %0d errors", name, errors - errBefore);
			testsFailed++;
		end
	endtask

	initial begin
		int          errStart;
		logic [31:0] rnd, rnd2;
		logic [1:0]  addr;
		void'($urandom(32'hb1178df2));
		{errors, checks, testsRun, testsFailed} = '0;
		clk       = 1'b0;
		rst       <= 1'b1;
		memAddr   <= '0;
		memDataIn <= '0;
		memWrEn   <= 1'b0;
		pinIn     <= '0;
		{uartTx, sdaOut, sclOut, tmr2Out, tmr3Out} <= 5'b11111; // Lines idle high.

		// Reset state.
		errStart = errors;
		for (int i = 1; i < RESET_CYCLES; i++) runCycle(1'b1, 2'd0, 16'd0, 1'b0, 16'd0, 5'h1f);
		for (int a = 0; a < 4; a++) begin
			runCycle(1'b0, 2'(a), 16'd0, 1'b0, 16'd0, 5'h1f);
			checkVal("o_memDataOut", memDataOut, 16'h0000);
			checkVal("o_pinOe", pinOe, 16'h0000);
			checkVal("o_intH", {15'd0, intH}, 16'h0000);
			checkVal("o_intL", {15'd0, intL}, 16'h0000);
		end
		endTest("reset state", errStart);

		// Direction and output registers, config stays off.
		errStart = errors;
		for (int i = 0; i < N_REGS; i++) begin
			rnd  = $urandom;
			rnd2 = $urandom;
			addr = (rnd[1:0] == 2'd0) ? 2'd2 : rnd[1:0];
			runCycle(1'b0, addr, rnd[31:16], rnd[2], rnd2[15:0], rnd2[20:16]);
		end
		endTest("register access", errStart);

		// Input synchronizer latency.
		errStart = errors;
		for (int i = 0; i < N_SYNC; i++) begin
			rnd = $urandom;
			runCycle(1'b0, 2'd1, rnd[31:16], 1'b0, rnd[15:0], rnd[20:16]);
		end
		endTest("input sync", errStart);

		// Alternate functions with random config.
		errStart = errors;
		for (int i = 0; i < N_ALT; i++) begin
			rnd  = $urandom;
			rnd2 = $urandom;
			runCycle(1'b0, rnd[1:0], rnd[31:16], rnd[2], rnd2[15:0], rnd2[20:16]);
			if (memAddr == 2'd0) checkVal("o_memDataOut reserved", memDataOut & 16'ha0fc, 16'h0);
		end
		endTest("alternate functions", errStart);

		// Interrupt edges with random enables and clears.
		errStart = errors;
		for (int i = 0; i < N_INT; i++) begin
			rnd  = $urandom;
			rnd2 = $urandom;
			addr = (rnd[4:3] == 2'd3) ? rnd[6:5] : 2'd0; // Mostly status reads.
			runCycle(1'b0, addr, rnd[31:16], (rnd[2:0] == 3'd0), rnd2[15:0], rnd2[20:16]);
		end
		endTest("interrupts", errStart);

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
		         testsRun, testsFailed, checks, errors);
		if (errors == 0) $display("TEST RESULT: PASS");
		else $display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: compile.f
gpioPkg.sv
pinSync.sv
gpioRegs.sv
intDetect.sv
pinMux.sv
gpioSubsystem.sv
tb_gpioSubsystem.sv

// File: run.sh
#!/bin/sh
# Build the GPIO testbench with Verilator, run it, and judge the log.

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_gpioSubsystem -o tbSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tbSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
	echo "No result line found in $LOG"
	exit 1
fi
exit 0
